//--- common/flash_audio_pkg.sv
package flash_audio_pkg;

  // ======================================================================
  // Flash word and sample formats
  // ======================================================================

  // Flash word address width
  localparam int ADDR_W = 23;

  // Flash data width
  localparam int WORD_W = 32;

  // One audio sample
  localparam int SAMPLE_W = 16;

  // Byte sent to the audio output
  localparam int AUDIO_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [SAMPLE_W-1:0] sample_t;

  // Upper sample sits in bits 31:16, lower in 15:0
  typedef struct packed {
    sample_t upper;
    sample_t lower;
  } sample_pair_t;

  // Same flash word, seen raw or as two samples
  typedef union packed {
    logic [WORD_W-1:0] raw;
    sample_pair_t      pair;
  } flash_word_t;

endpackage

//--- common/player_ctrl_pkg.sv
package player_ctrl_pkg;

  // ======================================================================
  // Keyboard commands, upper case ASCII
  // ======================================================================

  // Start playing
  localparam logic [7:0] KEY_START = 8'h45;
  // Pause
  localparam logic [7:0] KEY_PAUSE = 8'h44;
  // Play forward
  localparam logic [7:0] KEY_FORWARD = 8'h46;
  // Play backward
  localparam logic [7:0] KEY_BACKWARD = 8'h42;
  // Back to the start of the block
  localparam logic [7:0] KEY_RESTART = 8'h52;

  // Set in lower case letters only
  localparam logic [7:0] CASE_BIT = 8'h20;

  // ======================================================================
  // Sample rate control
  // ======================================================================

  localparam int DIV_W = 16;

  typedef logic [DIV_W-1:0] divisor_t;

endpackage

//--- verilog/key_command_decoder.sv
`timescale 1ns/1ns

module key_command_decoder (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic [7:0] kbd_ascii,
  input  logic       kbd_strobe,
  output logic       pause,
  output logic       direction,
  output logic       restart
);

  logic [7:0] key_upper;

  // Lower case letters folded onto upper case
  assign key_upper = kbd_ascii & ~player_ctrl_pkg::CASE_BIT;

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pause     <= 1'b1;
      direction <= 1'b1;
      restart   <= 1'b0;
    end
    else
    begin
      // One cycle pulse
      restart <= 1'b0;
      if (kbd_strobe)
      begin
        case (key_upper)
          player_ctrl_pkg::KEY_START:
            pause <= 1'b0;
          player_ctrl_pkg::KEY_PAUSE:
            pause <= 1'b1;
          player_ctrl_pkg::KEY_FORWARD:
            direction <= 1'b1;
          player_ctrl_pkg::KEY_BACKWARD:
            direction <= 1'b0;
          player_ctrl_pkg::KEY_RESTART:
            restart <= 1'b1;
          default:
          begin
            // Anything else is ignored
          end
        endcase
      end
    end
  end

endmodule

//--- verilog/sample_rate_gen.sv
`timescale 1ns/1ns

module sample_rate_gen #(
  parameter player_ctrl_pkg::divisor_t DEFAULT_DIVISOR = 16'd2268,
  parameter player_ctrl_pkg::divisor_t SPEED_STEP      = 16'd100,
  parameter player_ctrl_pkg::divisor_t MIN_DIVISOR     = 16'd1000,
  parameter player_ctrl_pkg::divisor_t MAX_DIVISOR     = 16'd5000
) (
  input  logic                      CLK_50M,
  input  logic                      rst_n,
  input  logic                      speed_up,
  input  logic                      speed_down,
  input  logic                      speed_reset,
  input  logic                      restart,
  output player_ctrl_pkg::divisor_t rate_divisor,
  output logic                      sample_tick
);

  player_ctrl_pkg::divisor_t div_next;
  player_ctrl_pkg::divisor_t tick_cnt;

  // ======================================================================
  // Speed control, clamped to MIN_DIVISOR .. MAX_DIVISOR
  // ======================================================================

  // Extra top bit keeps the bound checks free of wrap
  always_comb
  begin
    div_next = rate_divisor;
    if (speed_reset)
      div_next = DEFAULT_DIVISOR;
    else if (speed_up)
    begin
      if ({1'b0, rate_divisor} < {1'b0, MIN_DIVISOR} + {1'b0, SPEED_STEP})
        div_next = MIN_DIVISOR;
      else
        div_next = rate_divisor - SPEED_STEP;
    end
    else if (speed_down)
    begin
      if ({1'b0, rate_divisor} + {1'b0, SPEED_STEP} > {1'b0, MAX_DIVISOR})
        div_next = MAX_DIVISOR;
      else
        div_next = rate_divisor + SPEED_STEP;
    end
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      rate_divisor <= DEFAULT_DIVISOR;
    else
      rate_divisor <= div_next;
  end

  // ======================================================================
  // Tick counter, one pulse every rate_divisor cycles
  // ======================================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else if (restart)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    // >= so a smaller divisor never lets the count run past it
    else if (tick_cnt >= rate_divisor - 16'd1)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt + 16'd1;
      sample_tick <= 1'b0;
    end
  end

endmodule

//--- flash_reader/flash_reader.sv
`timescale 1ns/1ns

module flash_reader #(
  parameter flash_audio_pkg::addr_t LAST_ADDR = 23'h7FFFF
) (
  input  logic                                CLK_50M,
  input  logic                                rst_n,
  input  logic                                sample_tick,
  input  logic                                pause,
  input  logic                                direction,
  input  logic                                restart,
  output logic                                flash_read,
  output flash_audio_pkg::addr_t              flash_address,
  input  logic [flash_audio_pkg::WORD_W-1:0]  flash_readdata,
  input  logic                                flash_readdatavalid,
  output logic [flash_audio_pkg::AUDIO_W-1:0] audio_data,
  output logic                                sample_valid
);

  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_WAIT   = 2'd1;
  localparam logic [1:0] S_OUTPUT = 2'd2;

  logic [1:0]                  state;
  flash_audio_pkg::addr_t      cur_addr;
  // 1 selects the upper sample
  logic                        cur_half;
  // Position not yet played since reset or restart
  logic                        at_start;
  logic                        buf_valid;
  logic                        tick_held;
  // Outstanding read to throw away after a restart
  logic                        discard;
  flash_audio_pkg::flash_word_t buf_word;
  flash_audio_pkg::flash_word_t rd_word;
  flash_audio_pkg::addr_t      tgt_addr;
  logic                        tgt_half;
  logic                        serve_now;
  logic                        hit;
  logic                        load_word;

  // Upper byte of the chosen sample
  function automatic logic [flash_audio_pkg::AUDIO_W-1:0] top_byte(
    input flash_audio_pkg::flash_word_t word,
    input logic                         upper
  );
    flash_audio_pkg::sample_t smp;
    smp = upper ? word.pair.upper : word.pair.lower;
    return smp[flash_audio_pkg::SAMPLE_W-1 -: flash_audio_pkg::AUDIO_W];
  endfunction

  assign rd_word       = flash_readdata;
  assign flash_address = cur_addr;
  assign sample_valid  = (state == S_OUTPUT);

  // ======================================================================
  // Next sample position, stepped in the current direction
  // ======================================================================

  always_comb
  begin
    tgt_addr = cur_addr;
    tgt_half = cur_half;
    if (!at_start)
    begin
      if (direction)
      begin
        tgt_half = ~cur_half;
        if (cur_half)
          tgt_addr = (cur_addr == LAST_ADDR) ? '0 : cur_addr + 23'd1;
      end
      else
      begin
        tgt_half = ~cur_half;
        if (!cur_half)
          tgt_addr = (cur_addr == '0) ? LAST_ADDR : cur_addr - 23'd1;
      end
    end
  end

  assign serve_now = (state == S_IDLE) && (sample_tick || tick_held) && !pause;
  // Buffer always holds the word at cur_addr
  assign hit       = buf_valid && (tgt_addr == cur_addr);
  assign load_word = (state == S_WAIT) && flash_readdatavalid && !discard;

  // ======================================================================
  // Fetch FSM
  // ======================================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= S_IDLE;
      cur_addr   <= '0;
      cur_half   <= 1'b0;
      at_start   <= 1'b1;
      buf_valid  <= 1'b0;
      discard    <= 1'b0;
      flash_read <= 1'b0;
    end
    else if (restart)
    begin
      // A read still in flight is waited out and dropped
      state      <= (state == S_WAIT && !flash_readdatavalid) ? S_WAIT : S_IDLE;
      discard    <= (state == S_WAIT && !flash_readdatavalid);
      cur_addr   <= direction ? '0 : LAST_ADDR;
      cur_half   <= ~direction;
      at_start   <= 1'b1;
      buf_valid  <= 1'b0;
      flash_read <= 1'b0;
    end
    else
    begin
      flash_read <= 1'b0;
      case (state)
        S_IDLE:
          if (serve_now)
          begin
            cur_addr <= tgt_addr;
            cur_half <= tgt_half;
            at_start <= 1'b0;
            if (hit)
              state <= S_OUTPUT;
            else
            begin
              buf_valid  <= 1'b0;
              flash_read <= 1'b1;
              state      <= S_WAIT;
            end
          end
        S_WAIT:
          if (flash_readdatavalid)
          begin
            discard <= 1'b0;
            if (discard)
              state <= S_IDLE;
            else
            begin
              buf_valid <= 1'b1;
              state     <= S_OUTPUT;
            end
          end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // One tick held while busy, later ones are lost
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      tick_held <= 1'b0;
    else if (restart || pause || serve_now)
      tick_held <= 1'b0;
    else if (sample_tick && state != S_IDLE)
      tick_held <= 1'b1;
  end

  // Word buffer and audio byte
  always_ff @(posedge CLK_50M)
  begin
    if (load_word)
    begin
      buf_word   <= rd_word;
      audio_data <= top_byte(rd_word, cur_half);
    end
    else if (serve_now && hit)
      audio_data <= top_byte(buf_word, tgt_half);
  end

endmodule

//--- verilog/simple_ipod_top.sv
`timescale 1ns/1ns

module simple_ipod_top #(
  parameter flash_audio_pkg::addr_t   LAST_ADDR       = 23'h7FFFF,
  parameter player_ctrl_pkg::divisor_t DEFAULT_DIVISOR = 16'd2268,
  parameter player_ctrl_pkg::divisor_t SPEED_STEP      = 16'd100,
  parameter player_ctrl_pkg::divisor_t MIN_DIVISOR     = 16'd1000,
  parameter player_ctrl_pkg::divisor_t MAX_DIVISOR     = 16'd5000
) (
  input  logic                                 CLK_50M,
  input  logic                                 rst_n,
  input  logic [7:0]                           kbd_ascii,
  input  logic                                 kbd_strobe,
  input  logic                                 speed_up,
  input  logic                                 speed_down,
  input  logic                                 speed_reset,
  output logic                                 flash_read,
  output flash_audio_pkg::addr_t               flash_address,
  input  logic [flash_audio_pkg::WORD_W-1:0]   flash_readdata,
  input  logic                                 flash_readdatavalid,
  output logic [flash_audio_pkg::AUDIO_W-1:0]  audio_data,
  output logic                                 sample_valid,
  output player_ctrl_pkg::divisor_t            rate_divisor
);

  logic pause;
  logic direction;
  logic restart;
  logic sample_tick;

  // Keyboard commands
  key_command_decoder u_key_command_decoder (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .kbd_ascii  (kbd_ascii),
    .kbd_strobe (kbd_strobe),
    .pause      (pause),
    .direction  (direction),
    .restart    (restart)
  );

  // Sample rate tick
  sample_rate_gen #(
    .DEFAULT_DIVISOR (DEFAULT_DIVISOR),
    .SPEED_STEP      (SPEED_STEP),
    .MIN_DIVISOR     (MIN_DIVISOR),
    .MAX_DIVISOR     (MAX_DIVISOR)
  ) u_sample_rate_gen (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .speed_up     (speed_up),
    .speed_down   (speed_down),
    .speed_reset  (speed_reset),
    .restart      (restart),
    .rate_divisor (rate_divisor),
    .sample_tick  (sample_tick)
  );

  // Flash fetch and sample sequencing
  flash_reader #(
    .LAST_ADDR (LAST_ADDR)
  ) u_flash_reader (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .sample_tick         (sample_tick),
    .pause               (pause),
    .direction           (direction),
    .restart             (restart),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_data          (audio_data),
    .sample_valid        (sample_valid)
  );

endmodule

//--- bench/simple_ipod_asserts.sv
`timescale 1ns/1ns

module simple_ipod_asserts (
  input logic CLK_50M,
  input logic rst_n,
  input logic flash_read,
  input logic flash_readdatavalid,
  input logic sample_valid
);

  // Read issued and not yet answered
  logic outstanding;

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      outstanding <= 1'b0;
    else if (flash_read)
      outstanding <= 1'b1;
    else if (flash_readdatavalid)
      outstanding <= 1'b0;
  end

  read_single_cycle: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read |=> !flash_read)
    else $error("flash_read held high on two cycles in a row");

  read_one_outstanding: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read |-> !outstanding)
    else $error("flash_read issued while a read is outstanding");

  valid_single_cycle: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_valid |=> !sample_valid)
    else $error("sample_valid held high for more than one cycle");

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic CLK_50M,
  output logic rst_n
);

  initial
  begin
    CLK_50M = 1'b0;
    forever #HALF_PERIOD CLK_50M = ~CLK_50M;
  end

  // Reset released on a rising edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK_50M);
    rst_n <= 1'b1;
  end

endmodule

//--- bench/tb_simple_ipod.sv
`timescale 1ns/1ns

module tb_simple_ipod;

  localparam int LAST    = 15;
  localparam int DEF_DIV = 40;
  localparam int STEP    = 4;
  localparam int MIN_DIV = 16;
  localparam int MAX_DIV = 80;
  localparam int TIMEOUT = 8 * DEF_DIV;

  logic                         CLK_50M;
  logic                         rst_n;
  logic [7:0]                   kbd_ascii;
  logic                         kbd_strobe;
  logic                         speed_up;
  logic                         speed_down;
  logic                         speed_reset;
  logic                         flash_read;
  flash_audio_pkg::addr_t       flash_address;
  logic [31:0]                  flash_readdata = 32'h0;
  logic                         flash_readdatavalid = 1'b0;
  logic [7:0]                   audio_data;
  logic                         sample_valid;
  player_ctrl_pkg::divisor_t    rate_divisor;

  flash_audio_pkg::flash_word_t mem [0:15];
  integer                       seed = 32'h54915f47;

  // Reference model state
  int   exp_addr;
  logic exp_half;
  logic exp_start;
  logic exp_dir;
  int   exp_div;
  int   errors;
  int   err_mark;
  int   checks;
  int   tests_run;
  int   tests_failed;
  int   rd_checked;

  tb_clock_gen u_clock_gen (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n)
  );

  simple_ipod_top #(
    .LAST_ADDR       (23'(LAST)),
    .DEFAULT_DIVISOR (16'(DEF_DIV)),
    .SPEED_STEP      (16'(STEP)),
    .MIN_DIVISOR     (16'(MIN_DIV)),
    .MAX_DIVISOR     (16'(MAX_DIV))
  ) DUT (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .kbd_ascii           (kbd_ascii),
    .kbd_strobe          (kbd_strobe),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_data          (audio_data),
    .sample_valid        (sample_valid),
    .rate_divisor        (rate_divisor)
  );

  bind flash_reader simple_ipod_asserts u_asserts (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .flash_read          (flash_read),
    .flash_readdatavalid (flash_readdatavalid),
    .sample_valid        (sample_valid)
  );

  // ======================================================================
  // Flash memory, answers each read after 1 to 4 cycles
  // ======================================================================

  logic [3:0]             rd_addr;
  logic [2:0]             rd_wait;
  logic                   rd_busy = 1'b0;
  logic [31:0]            rd_rnd;
  // Full address of the latest read and how many reads were seen
  flash_audio_pkg::addr_t last_rd_addr;
  int                     rd_count = 0;

  always @(posedge CLK_50M)
  begin
    flash_readdatavalid <= 1'b0;
    if (flash_read)
    begin
      rd_rnd = $random(seed);
      rd_addr      <= flash_address[3:0];
      rd_wait      <= {1'b0, rd_rnd[1:0]} + 3'd1;
      rd_busy      <= 1'b1;
      last_rd_addr <= flash_address;
      rd_count     <= rd_count + 1;
    end
    else if (rd_busy)
    begin
      if (rd_wait == 3'd1)
      begin
        flash_readdata      <= mem[rd_addr].raw;
        flash_readdatavalid <= 1'b1;
        rd_busy             <= 1'b0;
      end
      else
        rd_wait <= rd_wait - 3'd1;
    end
  end

  // ======================================================================
  // Reference model and checks
  // ======================================================================

  // Next position, nothing moves on the first sample after a restart
  task automatic model_step();
    if (exp_start)
      exp_start = 1'b0;
    else if (exp_dir)
    begin
      if (exp_half)
        exp_addr = (exp_addr == LAST) ? 0 : exp_addr + 1;
      exp_half = ~exp_half;
    end
    else
    begin
      if (!exp_half)
        exp_addr = (exp_addr == 0) ? LAST : exp_addr - 1;
      exp_half = ~exp_half;
    end
  endtask

  function automatic logic [7:0] expected_byte();
    flash_audio_pkg::flash_word_t word;
    word = mem[exp_addr[3:0]];
    if (exp_half)
      return word.pair.upper[15:8];
    return word.pair.lower[15:8];
  endfunction

  task automatic compare_audio();
    logic [7:0] exp_byte;
    model_step();
    exp_byte = expected_byte();
    checks++;
    if (audio_data !== exp_byte)
    begin
      errors++;
      $display("CHECK FAILED audio_data: expected %h, got %h (word %0d, half %0d)",
               exp_byte, audio_data, exp_addr, exp_half);
    end
    // A fetch since the last sample must have read this sample's word
    if (rd_count != rd_checked)
    begin
      rd_checked = rd_count;
      checks++;
      if (last_rd_addr !== 23'(exp_addr))
      begin
        errors++;
        $display("CHECK FAILED flash_address: expected %h, got %h",
                 23'(exp_addr), last_rd_addr);
      end
    end
  endtask

  task automatic check_sample();
    int n;
    @(posedge CLK_50M);
    for (n = 0; n < TIMEOUT && !sample_valid; n++)
      @(posedge CLK_50M);
    if (!sample_valid)
    begin
      errors++;
      $display("ERROR: no sample_valid within %0d cycles", TIMEOUT);
    end
    else
      compare_audio();
  endtask

  // Counts samples and reads, checking any sample that shows up
  task automatic quiet_window(input int cycles, input int allowed);
    int samples;
    int reads;
    samples = 0;
    reads = 0;
    repeat (cycles)
    begin
      @(posedge CLK_50M);
      if (flash_read)
        reads++;
      if (sample_valid)
      begin
        samples++;
        compare_audio();
      end
    end
    checks++;
    if (samples > allowed || reads > allowed)
    begin
      errors++;
      $display("ERROR: %0d samples and %0d flash reads seen, at most %0d expected",
               samples, reads, allowed);
    end
  endtask

  task automatic send_key(input logic [7:0] code);
    logic [7:0] key;
    key = code & ~player_ctrl_pkg::CASE_BIT;
    @(posedge CLK_50M);
    kbd_ascii  <= code;
    kbd_strobe <= 1'b1;
    @(posedge CLK_50M);
    kbd_strobe <= 1'b0;
    @(posedge CLK_50M);
    if (key == player_ctrl_pkg::KEY_FORWARD)
      exp_dir = 1'b1;
    else if (key == player_ctrl_pkg::KEY_BACKWARD)
      exp_dir = 1'b0;
    else if (key == player_ctrl_pkg::KEY_RESTART)
    begin
      exp_start = 1'b1;
      exp_addr  = exp_dir ? 0 : LAST;
      exp_half  = ~exp_dir;
    end
  endtask

  // Kind 0 resets, 1 speeds up, 2 slows down
  task automatic speed_pulse(input int kind);
    @(posedge CLK_50M);
    speed_reset <= (kind == 0);
    speed_up    <= (kind == 1);
    speed_down  <= (kind == 2);
    @(posedge CLK_50M);
    speed_reset <= 1'b0;
    speed_up    <= 1'b0;
    speed_down  <= 1'b0;
    if (kind == 0)
      exp_div = DEF_DIV;
    else if (kind == 1)
      exp_div = (exp_div - STEP < MIN_DIV) ? MIN_DIV : exp_div - STEP;
    else
      exp_div = (exp_div + STEP > MAX_DIV) ? MAX_DIV : exp_div + STEP;
    // New divisor due one cycle after the pulse
    @(posedge CLK_50M);
    checks++;
    if (int'(rate_divisor) != exp_div)
    begin
      errors++;
      $display("CHECK FAILED rate_divisor: expected %h, got %h", exp_div, rate_divisor);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark)
      $display("test %-22s ok", name);
    else
    begin
      tests_failed++;
      $display("test %-22s %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================

  initial
  begin
    int n;
    int kind;
    kbd_ascii   = 8'h00;
    kbd_strobe  = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    exp_addr    = 0;
    exp_half    = 1'b0;
    exp_start   = 1'b1;
    exp_dir     = 1'b1;
    exp_div     = DEF_DIV;
    errors      = 0;
    err_mark    = 0;
    checks      = 0;
    tests_run   = 0;
    tests_failed = 0;
    rd_checked  = 0;
    for (int i = 0; i < 16; i++)
      mem[i[3:0]].raw = $random(seed);

    for (n = 0; n < 100 && rst_n !== 1'b1; n++)
      @(posedge CLK_50M);
    if (rst_n !== 1'b1)
    begin
      errors++;
      $display("ERROR: reset was never released");
    end

    quiet_window(10 * DEF_DIV, 0);
    checks++;
    if (int'(rate_divisor) != DEF_DIV)
    begin
      errors++;
      $display("CHECK FAILED rate_divisor: expected %h, got %h", DEF_DIV, rate_divisor);
    end
    end_test("reset and idle");

    // Lower case start key
    send_key(8'h65);
    repeat (40) check_sample();
    end_test("forward with wrap");

    send_key(player_ctrl_pkg::KEY_BACKWARD);
    repeat (20) check_sample();
    end_test("backward playback");

    send_key(player_ctrl_pkg::KEY_PAUSE);
    // One sample may still be on its way
    quiet_window(DEF_DIV, 1);
    quiet_window(5 * DEF_DIV, 0);
    send_key(player_ctrl_pkg::KEY_START);
    repeat (4) check_sample();
    end_test("pause and resume");

    send_key(player_ctrl_pkg::KEY_PAUSE);
    quiet_window(5 * DEF_DIV, 1);
    send_key(player_ctrl_pkg::KEY_FORWARD);
    send_key(player_ctrl_pkg::KEY_RESTART);
    send_key(player_ctrl_pkg::KEY_START);
    check_sample();
    send_key(player_ctrl_pkg::KEY_PAUSE);
    quiet_window(5 * DEF_DIV, 1);
    send_key(player_ctrl_pkg::KEY_BACKWARD);
    send_key(player_ctrl_pkg::KEY_RESTART);
    send_key(player_ctrl_pkg::KEY_START);
    repeat (2) check_sample();
    end_test("restart");

    send_key(player_ctrl_pkg::KEY_PAUSE);
    for (n = 0; n < 30; n++)
    begin
      kind = $unsigned($random(seed)) % 3;
      speed_pulse(kind);
    end
    // Driven past both limits
    repeat (20) speed_pulse(1);
    checks++;
    if (rate_divisor != 16'(MIN_DIV))
    begin
      errors++;
      $display("CHECK FAILED rate_divisor: expected %h, got %h", MIN_DIV, rate_divisor);
    end
    repeat (20) speed_pulse(2);
    checks++;
    if (rate_divisor != 16'(MAX_DIV))
    begin
      errors++;
      $display("CHECK FAILED rate_divisor: expected %h, got %h", MAX_DIV, rate_divisor);
    end
    speed_pulse(0);
    end_test("speed control");

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- simple_ipod.f
common/flash_audio_pkg.sv
common/player_ctrl_pkg.sv
verilog/key_command_decoder.sv
verilog/sample_rate_gen.sv
flash_reader/flash_reader.sv
verilog/simple_ipod_top.sv
bench/simple_ipod_asserts.sv
bench/tb_clock_gen.sv
bench/tb_simple_ipod.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_simple_ipod -f simple_ipod.f \
  -o tb_simple_ipod > build.log 2>&1 \
  && ./obj_dir/tb_simple_ipod > sim.log 2>&1 \
  || echo "build or run stopped with an error, see build.log and sim.log"
grep -q "SIMULATION PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
